//--- Makefile
# Verilator build, run and lint for the load/store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
LINT_TOP  ?= lsu_top
FLIST     ?= lsu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINT_SRCS ?= $(shell grep '^logic/' $(FLIST))
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# status comes from the pass line in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(LINT_SRCS) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/data_mem.sv
//------------------------------
// byte-writable data memory
// per-lane write enables, registered word read
//------------------------------
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  lsu_pkg::byte_en_t be,
    input  logic              rd,
    input  lsu_pkg::word_t    addr,
    input  lsu_pkg::word_t    wdata,
    output lsu_pkg::word_t    rdata
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int LANES = XLEN / 8;

    logic [LANES-1:0][7:0] mem [MEM_WORDS];  // word array, byte lanes
    logic [IDX_W-1:0]      widx;             // word index

    assign widx = addr[IDX_W+1:2];  // drop the byte offset

    // lane writes, each lane on its own enable
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (be[i]) begin
                mem[widx][i] <= wdata[8*i +: 8];
            end
        end
    end

    // whole word read, held until the next read
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[widx];
        end
    end

    // controller never issues a read and a write in the same cycle
    a_no_rd_wr: assert property (@(posedge clk) !((|be) && rd))
        else $error("data_mem: read and write enabled together");

endmodule

//--- logic/load_extend.sv
//------------------------------
// load data extraction
// picks the addressed byte or half and extends it
//------------------------------
`timescale 1ns/1ps

module load_extend (
    input  lsu_pkg::mem_op_e op,
    input  logic [1:0]       byte_off,
    input  lsu_pkg::word_t   rdata,
    output lsu_pkg::word_t   load_value
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;  // addressed byte
    logic [15:0] sel_half;  // addressed half

    always_comb begin
        case (byte_off)
            2'd0:    sel_byte = rdata[7:0];
            2'd1:    sel_byte = rdata[15:8];
            2'd2:    sel_byte = rdata[23:16];
            default: sel_byte = rdata[31:24];
        endcase
    end

    // bit 0 is zero for any aligned half
    assign sel_half = byte_off[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (op)
            OP_LB:   load_value = {{(XLEN-8){sel_byte[7]}}, sel_byte};    // sign fill
            OP_LBU:  load_value = {{(XLEN-8){1'b0}}, sel_byte};
            OP_LH:   load_value = {{(XLEN-16){sel_half[15]}}, sel_half};  // sign fill
            OP_LHU:  load_value = {{(XLEN-16){1'b0}}, sel_half};
            OP_LW:   load_value = rdata;  // raw word
            default: load_value = '0;     // stores return nothing
        endcase
    end

endmodule

//--- logic/lsu_align.sv
//------------------------------
// store lane steering and alignment check
// purely combinational, fed from the held request
//------------------------------
`timescale 1ns/1ps

module lsu_align (
    input  lsu_pkg::mem_op_e  op,
    input  lsu_pkg::word_t    addr,
    input  lsu_pkg::word_t    wdata,
    output lsu_pkg::byte_en_t lane_be,
    output lsu_pkg::word_t    lane_wdata,
    output logic              misaligned
);
    import lsu_pkg::*;

    logic [1:0] off;  // byte offset in the word

    assign off = addr[1:0];

    always_comb begin
        lane_be    = '0;     // loads never write
        lane_wdata = wdata;
        misaligned = 1'b0;
        case (op)
            OP_SB: begin
                lane_be    = byte_en_t'(4'b0001 << off);
                lane_wdata = {4{wdata[7:0]}};   // byte on every lane
            end
            OP_SH: begin
                lane_be    = off[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{wdata[15:0]}};  // half on both halves
                misaligned = off[0];
            end
            OP_SW: begin
                lane_be    = 4'b1111;           // full word store
                misaligned = |off;
            end
            OP_LH, OP_LHU: begin
                misaligned = off[0];            // must sit on a half boundary
            end
            OP_LW: begin
                misaligned = |off;
            end
            default: begin
                // byte loads are always aligned
                misaligned = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/lsu_ctrl.sv
//------------------------------
// request/response controller for the lsu
// holds one request, gates the memory, drives the response
//------------------------------
`timescale 1ns/1ps

module lsu_ctrl #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  lsu_pkg::mem_op_e  req_op,
    input  lsu_pkg::word_t    req_addr,
    input  lsu_pkg::word_t    req_wdata,
    input  logic              rsp_ready,
    input  logic              misaligned,
    input  lsu_pkg::byte_en_t lane_be,
    input  lsu_pkg::word_t    load_value,
    output logic              req_ready,
    output lsu_pkg::mem_op_e  cur_op,
    output lsu_pkg::word_t    cur_addr,
    output lsu_pkg::word_t    cur_wdata,
    output lsu_pkg::byte_en_t mem_be,
    output logic              mem_rd,
    output logic              rsp_valid,
    output lsu_pkg::word_t    rsp_data,
    output logic              rsp_err
);
    import lsu_pkg::*;

    lsu_state_e state, state_nxt;
    logic       range_fault;  // word index beyond the array
    logic       fault;        // any reason to skip the access
    logic       is_store;
    logic       err_q;        // fault seen in the access cycle

    assign is_store    = cur_op inside {OP_SB, OP_SH, OP_SW};
    assign range_fault = cur_addr[XLEN-1:2] >= (XLEN-2)'(MEM_WORDS);
    assign fault       = misaligned | range_fault;

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESP);

    // memory strobes only in the access cycle and only when clean
    assign mem_be = (state == ST_ACCESS && !fault) ? lane_be : '0;
    assign mem_rd = (state == ST_ACCESS) && !fault && !is_store;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (req_valid) state_nxt = ST_ACCESS;  // accept
            ST_ACCESS: state_nxt = ST_RESP;
            ST_RESP:   if (rsp_ready) state_nxt = ST_IDLE;    // response taken
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_ACCESS) begin
                err_q <= fault;  // held for the whole response
            end
        end
    end

    // request payload, captured on the accept edge
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_op    <= req_op;
            cur_addr  <= req_addr;
            cur_wdata <= req_wdata;
        end
    end

    // error or store gives zero data
    assign rsp_data = (rsp_valid && !err_q && !is_store) ? load_value : '0;
    assign rsp_err  = rsp_valid && err_q;

    // held response must not move under back-pressure
    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> ($stable(rsp_data) && $stable(rsp_err)))
        else $error("lsu_ctrl: response changed while held");

    a_mem_gated: assert property (@(posedge clk) disable iff (!rst_n)
        (state != ST_ACCESS) |-> (mem_be == '0 && !mem_rd))
        else $error("lsu_ctrl: memory strobe outside access cycle");

endmodule

//--- logic/lsu_pkg.sv
//------------------------------
// shared types for the load/store unit
// imported by the lsu blocks and the testbench
//------------------------------

package lsu_pkg;

    // data path width, fixed by the rv32 opcodes
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   word_t;     // data or address word
    typedef logic [XLEN/8-1:0] byte_en_t;  // one enable per byte lane

    // memory opcodes
    // bit 3 marks a store, low bits follow the rv32 funct3 size code
    typedef enum logic [3:0] {
        OP_LB  = 4'h0,
        OP_LH  = 4'h1,
        OP_LW  = 4'h2,
        OP_LBU = 4'h4,
        OP_LHU = 4'h5,
        OP_SB  = 4'h8,
        OP_SH  = 4'h9,
        OP_SW  = 4'hA
    } mem_op_e;

    // controller states, one operation in flight
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,  // waiting for a request
        ST_ACCESS = 2'd1,  // memory write or read cycle
        ST_RESP   = 2'd2   // holding the response
    } lsu_state_e;

endpackage

//--- logic/lsu_top.sv
//------------------------------
// load/store unit top level
// valid/ready request in, valid/ready response out
//------------------------------
`timescale 1ns/1ps

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  lsu_pkg::mem_op_e req_op,
    input  lsu_pkg::word_t   req_addr,
    input  lsu_pkg::word_t   req_wdata,
    input  logic             rsp_ready,
    output logic             req_ready,
    output logic             rsp_valid,
    output lsu_pkg::word_t   rsp_data,
    output logic             rsp_err
);
    import lsu_pkg::*;

    mem_op_e  cur_op;
    word_t    cur_addr, cur_wdata;
    byte_en_t lane_be, mem_be;
    word_t    lane_wdata;
    logic     misaligned;
    logic     mem_rd;
    word_t    mem_rdata;
    word_t    load_value;

    lsu_ctrl #(.MEM_WORDS(MEM_WORDS)) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .rsp_ready  (rsp_ready),
        .misaligned (misaligned),
        .lane_be    (lane_be),
        .load_value (load_value),
        .req_ready  (req_ready),
        .cur_op     (cur_op),
        .cur_addr   (cur_addr),
        .cur_wdata  (cur_wdata),
        .mem_be     (mem_be),
        .mem_rd     (mem_rd),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_err    (rsp_err)
    );

    lsu_align u_align (
        .op         (cur_op),
        .addr       (cur_addr),
        .wdata      (cur_wdata),
        .lane_be    (lane_be),
        .lane_wdata (lane_wdata),
        .misaligned (misaligned)
    );

    data_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk   (clk),
        .be    (mem_be),
        .rd    (mem_rd),
        .addr  (cur_addr),
        .wdata (lane_wdata),
        .rdata (mem_rdata)
    );

    // byte offset taken straight from the held address
    load_extend u_ext (
        .op         (cur_op),
        .byte_off   (cur_addr[1:0]),
        .rdata      (mem_rdata),
        .load_value (load_value)
    );

endmodule

//--- lsu.f
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/data_mem.sv
logic/load_extend.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
verif/lsu_tb.sv

//--- verif/lsu_tb.sv
//------------------------------
// testbench for lsu_top
// runs a table of loads and stores, random response back-pressure
//------------------------------
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int  TB_WORDS   = 64;     // small memory, easy range faults
    localparam int  RST_CYCLES = 10;
    localparam int  SEED       = 89763;
    localparam time DRV_DLY    = 1ns;    // drive point after the edge

    logic    clk;
    logic    rst_n;
    logic    req_valid;
    mem_op_e req_op;
    word_t   req_addr;
    word_t   req_wdata;
    logic    rsp_ready;
    logic    req_ready;
    logic    rsp_valid;
    word_t   rsp_data;
    logic    rsp_err;

    // stimulus and expected response, one entry per operation
    mem_op_e tbl_op[$];
    word_t   tbl_addr[$];
    word_t   tbl_wdata[$];
    word_t   tbl_data[$];
    logic    tbl_err[$];
    logic    tbl_ready = 1'b0;

    int data_errs  = 0;
    int flag_errs  = 0;
    int proto_errs = 0;

    lsu_top #(.MEM_WORDS(TB_WORDS)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_ready (rsp_ready),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    task automatic add_entry(input mem_op_e op, input word_t addr, input word_t wdata,
                             input word_t exp_data, input logic exp_err);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_data.push_back(exp_data);
        tbl_err.push_back(exp_err);
    endtask

    task automatic build_table();
        // word 0 and 1, plain word traffic
        add_entry(OP_SW,  32'h000, 32'h1122_3344, 32'h0, 1'b0);
        add_entry(OP_SW,  32'h004, 32'hA5B6_C7D8, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h000, 32'h0, 32'h1122_3344, 1'b0);
        add_entry(OP_LW,  32'h004, 32'h0, 32'hA5B6_C7D8, 1'b0);
        // word 2 built up lane by lane, junk in upper store bits
        add_entry(OP_SW,  32'h008, 32'h0, 32'h0, 1'b0);
        add_entry(OP_SB,  32'h008, 32'hFFFF_FFAA, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h008, 32'h0, 32'h0000_00AA, 1'b0);
        add_entry(OP_SB,  32'h009, 32'h0000_00BB, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h008, 32'h0, 32'h0000_BBAA, 1'b0);
        add_entry(OP_SB,  32'h00A, 32'h1234_56CC, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h008, 32'h0, 32'h00CC_BBAA, 1'b0);
        add_entry(OP_SB,  32'h00B, 32'h0000_00DD, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h008, 32'h0, 32'hDDCC_BBAA, 1'b0);
        add_entry(OP_SH,  32'h008, 32'hFFFF_1234, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h008, 32'h0, 32'hDDCC_1234, 1'b0);
        add_entry(OP_SH,  32'h00A, 32'h0000_5678, 32'h0, 1'b0);
        add_entry(OP_LW,  32'h008, 32'h0, 32'h5678_1234, 1'b0);
        // word 3, bytes 85 7f 8c f0 from lane 0 up
        add_entry(OP_SW,  32'h00C, 32'hF08C_7F85, 32'h0, 1'b0);
        add_entry(OP_LB,  32'h00C, 32'h0, 32'hFFFF_FF85, 1'b0);
        add_entry(OP_LBU, 32'h00C, 32'h0, 32'h0000_0085, 1'b0);
        add_entry(OP_LB,  32'h00E, 32'h0, 32'hFFFF_FF8C, 1'b0);
        add_entry(OP_LH,  32'h00C, 32'h0, 32'h0000_7F85, 1'b0);  // top bit clear
        add_entry(OP_LH,  32'h00E, 32'h0, 32'hFFFF_F08C, 1'b0);
        add_entry(OP_LHU, 32'h00E, 32'h0, 32'h0000_F08C, 1'b0);
        add_entry(OP_LW,  32'h00C, 32'h0, 32'hF08C_7F85, 1'b0);
        // misaligned accesses, stores aimed at word 0
        add_entry(OP_LH,  32'h00D, 32'h0, 32'h0, 1'b1);
        add_entry(OP_LW,  32'h006, 32'h0, 32'h0, 1'b1);
        add_entry(OP_SH,  32'h001, 32'h0000_FFFF, 32'h0, 1'b1);
        add_entry(OP_SW,  32'h002, 32'hFFFF_FFFF, 32'h0, 1'b1);
        add_entry(OP_LW,  32'h000, 32'h0, 32'h1122_3344, 1'b0);
        // word index 64 and up, low index bits alias word 0
        add_entry(OP_SW,  32'h100, 32'hDEAD_BEEF, 32'h0, 1'b1);
        add_entry(OP_SB,  32'h103, 32'h0000_0077, 32'h0, 1'b1);
        add_entry(OP_LW,  32'h100, 32'h0, 32'h0, 1'b1);
        add_entry(OP_LW,  32'h000, 32'h0, 32'h1122_3344, 1'b0);
        tbl_ready = 1'b1;
    endtask

    task automatic check_data(input int idx, input string name, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            data_errs++;
            $display("[ERROR] t=%0t entry %0d %s expected %h actual %h",
                     $time, idx, name, exp, act);
        end
    endtask

    task automatic check_err(input int idx, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("[ERROR] t=%0t entry %0d rsp_err expected %b actual %b",
                     $time, idx, exp, act);
        end
    endtask

    // handshake timing bits
    task automatic check_flag(input int idx, input string name, input logic exp,
                              input logic act);
        if (act !== exp) begin
            proto_errs++;
            $display("[ERROR] t=%0t entry %0d %s expected %b actual %b",
                     $time, idx, name, exp, act);
        end
    endtask

    task automatic check_stable(input int idx, input word_t held_data, input logic held_err);
        if (rsp_data !== held_data || rsp_err !== held_err) begin
            proto_errs++;
            $display("entry %0d: held response changed at %0t before it was taken",
                     idx, $time);
        end
    endtask

    // one full request/response exchange, entered just after an edge
    task automatic run_entry(input int idx);
        word_t held_data;
        logic  held_err;
        req_op    = tbl_op[idx];
        req_addr  = tbl_addr[idx];
        req_wdata = tbl_wdata[idx];
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #DRV_DLY;
        end
        @(posedge clk);  // acceptance edge
        #DRV_DLY;
        req_valid = 1'b0;
        check_flag(idx, "req_ready", 1'b0, req_ready);
        check_flag(idx, "rsp_valid", 1'b0, rsp_valid);  // access cycle
        @(posedge clk);
        #DRV_DLY;
        check_flag(idx, "rsp_valid", 1'b1, rsp_valid);  // second edge
        check_data(idx, "rsp_data", tbl_data[idx], rsp_data);
        check_err(idx, tbl_err[idx], rsp_err);
        held_data = rsp_data;
        held_err  = rsp_err;
        while (rsp_valid) begin
            check_flag(idx, "req_ready", 1'b0, req_ready);
            check_stable(idx, held_data, held_err);
            @(posedge clk);
            #DRV_DLY;
        end
        check_flag(idx, "req_ready", 1'b1, req_ready);  // free again after handshake
    endtask

    // response back-pressure, ready low about 40% of cycles
    initial begin
        void'($urandom(SEED));
        rsp_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #DRV_DLY;
            rsp_ready = ($urandom % 100) >= 40;
        end
    end

    // watchdog scaled to the table
    initial begin
        wait (tbl_ready);
        repeat (tbl_op.size() * 40 + RST_CYCLES) @(posedge clk);
        $display("timeout: table did not finish in time, a handshake never completed");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int total;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_LW;
        req_addr  = '0;
        req_wdata = '0;
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        check_flag(-1, "req_ready", 1'b1, req_ready);  // idle out of reset
        check_flag(-1, "rsp_valid", 1'b0, rsp_valid);
        for (int i = 0; i < tbl_op.size(); i++) begin
            run_entry(i);
        end
        total = data_errs + flag_errs + proto_errs;
        $display("done: %0d entries, %0d data errors, %0d rsp_err errors, %0d protocol errors",
                 tbl_op.size(), data_errs, flag_errs, proto_errs);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
